//--- mips_core.f
+incdir+rtl
rtl/mips_pkg.sv
rtl/fetch_decode.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/forward_unit.sv
rtl/execute_stage.sv
rtl/mem_writeback.sv
rtl/mips.sv
tests/mips_tb.sv

//--- rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  mips_pkg::alu_op_t   alu_op,
	input  logic                use_imm,
	input  logic                zero_ext,
	input  mips_pkg::reg_addr_t dest,
	input  logic                reg_write,
	input  logic                mem_write,
	input  mips_pkg::reg_addr_t rs,
	input  mips_pkg::reg_addr_t rt,
	input  logic [15:0]         imm,
	input  mips_pkg::word_t     rs_data,
	input  mips_pkg::word_t     rt_data,
	input  mips_pkg::fwd_sel_t  fwd_a,
	input  mips_pkg::fwd_sel_t  fwd_b,
	input  mips_pkg::word_t     m_result,
	input  mips_pkg::word_t     w_result,
	output mips_pkg::reg_addr_t e_rs,
	output mips_pkg::reg_addr_t e_rt,
	output mips_pkg::word_t     e_result,
	output mips_pkg::word_t     e_store_data,
	output mips_pkg::reg_addr_t e_dest,
	output logic                e_reg_write,
	output logic                e_mem_write
);
	mips_pkg::alu_op_t e_alu_op;
	logic              e_use_imm;
	logic              e_zero_ext;
	logic [15:0]       e_imm;
	mips_pkg::word_t   e_rs_data;
	mips_pkg::word_t   e_rt_data;
	mips_pkg::word_t   op_a;
	mips_pkg::word_t   op_b;
	mips_pkg::word_t   imm_ext;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			e_reg_write <= 1'b0;
			e_mem_write <= 1'b0;
		end else begin
			e_reg_write <= reg_write;
			e_mem_write <= mem_write;
		end
	end

	always_ff @(posedge clk) begin
		e_alu_op   <= alu_op;
		e_use_imm  <= use_imm;
		e_zero_ext <= zero_ext;
		e_dest     <= dest;
		e_rs       <= rs;
		e_rt       <= rt;
		e_imm      <= imm;
		e_rs_data  <= rs_data;
		e_rt_data  <= rt_data;
	end

	function automatic mips_pkg::word_t fwd_mux(input mips_pkg::fwd_sel_t sel,
			input mips_pkg::word_t reg_val);
		case (sel)
			mips_pkg::fwd_from_m: return m_result;
			mips_pkg::fwd_from_w: return w_result;
			default:              return reg_val;
		endcase
	endfunction

	always_comb begin
		op_a = fwd_mux(fwd_a, e_rs_data);
		// Store data is the forwarded rt, before the immediate select
		e_store_data = fwd_mux(fwd_b, e_rt_data);
		imm_ext = e_zero_ext ? {16'h0000, e_imm} : {{16{e_imm[15]}}, e_imm};
		op_b = e_use_imm ? imm_ext : e_store_data;
	end

	always_comb begin
		case (e_alu_op)
			mips_pkg::alu_sub: e_result = op_a - op_b;
			mips_pkg::alu_and: e_result = op_a & op_b;
			mips_pkg::alu_or:  e_result = op_a | op_b;
			mips_pkg::alu_slt: e_result = {31'd0, $signed(op_a) < $signed(op_b)};
			mips_pkg::alu_lui: e_result = {op_b[15:0], 16'h0000};
			default:           e_result = op_a + op_b;
		endcase
	end

endmodule

//--- rtl/fetch_decode.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module fetch_decode (
	input  logic                clk,
	input  logic                rst_n,
	input  mips_pkg::word_t     instr,
	output mips_pkg::pc_t       pc_out,
	output mips_pkg::opcode_t   opcode,
	output mips_pkg::funct_t    funct,
	output mips_pkg::reg_addr_t rs,
	output mips_pkg::reg_addr_t rt,
	output mips_pkg::reg_addr_t rd,
	output logic [15:0]         imm
);
	mips_pkg::word_t instr_d;

	// PC only counts up, instr arrives in the same cycle as pc_out
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc_out  <= `RESET_PC;
			instr_d <= '0;
		end else begin
			pc_out  <= pc_out + 30'd1;
			instr_d <= instr;
		end
	end

	// All-zero word is sll $0, which decodes to a no-op
	assign opcode = instr_d[31:26];
	assign rs     = instr_d[25:21];
	assign rt     = instr_d[20:16];
	assign rd     = instr_d[15:11];
	assign imm    = instr_d[15:0];
	assign funct  = instr_d[5:0];

	property p_pc_step;
		@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> (pc_out == $past(pc_out) + 30'd1);
	endproperty

	a_pc_step: assert property (p_pc_step)
		else $error("pc_out did not advance by one word");

endmodule

//--- rtl/forward_unit.sv
`timescale 1ns/1ps

module forward_unit (
	input  mips_pkg::reg_addr_t e_rs,
	input  mips_pkg::reg_addr_t e_rt,
	input  mips_pkg::reg_addr_t m_dest,
	input  logic                m_reg_write,
	input  mips_pkg::reg_addr_t w_dest,
	input  logic                w_reg_write,
	output mips_pkg::fwd_sel_t  fwd_a,
	output mips_pkg::fwd_sel_t  fwd_b
);

	// Younger result in M wins over W, register zero is never forwarded
	function automatic mips_pkg::fwd_sel_t pick(input mips_pkg::reg_addr_t src);
		if (m_reg_write && m_dest != 5'd0 && m_dest == src) begin
			return mips_pkg::fwd_from_m;
		end else if (w_reg_write && w_dest != 5'd0 && w_dest == src) begin
			return mips_pkg::fwd_from_w;
		end
		return mips_pkg::fwd_from_reg;
	endfunction

	always_comb begin
		fwd_a = pick(e_rs);
		fwd_b = pick(e_rt);
	end

endmodule

//--- rtl/instr_decoder.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module instr_decoder (
	input  mips_pkg::opcode_t   opcode,
	input  mips_pkg::funct_t    funct,
	input  mips_pkg::reg_addr_t rt,
	input  mips_pkg::reg_addr_t rd,
	output mips_pkg::alu_op_t   alu_op,
	output logic                use_imm,
	output logic                zero_ext,
	output mips_pkg::reg_addr_t dest,
	output logic                reg_write,
	output logic                mem_write
);

	always_comb begin
		// Anything not listed falls through as a no-op
		alu_op    = mips_pkg::alu_add;
		use_imm   = 1'b0;
		zero_ext  = 1'b0;
		dest      = `REG_ZERO;
		reg_write = 1'b0;
		mem_write = 1'b0;
		case (opcode)
			`OP_SPECIAL: begin
				dest = rd;
				reg_write = 1'b1;
				case (funct)
					`FN_ADDU: alu_op = mips_pkg::alu_add;
					`FN_SUBU: alu_op = mips_pkg::alu_sub;
					`FN_AND:  alu_op = mips_pkg::alu_and;
					`FN_OR:   alu_op = mips_pkg::alu_or;
					`FN_SLT:  alu_op = mips_pkg::alu_slt;
					default: begin
						dest = `REG_ZERO;
						reg_write = 1'b0;
					end
				endcase
			end
			`OP_ADDIU: begin
				use_imm   = 1'b1;
				dest      = rt;
				reg_write = 1'b1;
			end
			`OP_ORI: begin
				alu_op    = mips_pkg::alu_or;
				use_imm   = 1'b1;
				zero_ext  = 1'b1;
				dest      = rt;
				reg_write = 1'b1;
			end
			`OP_LUI: begin
				alu_op    = mips_pkg::alu_lui;
				use_imm   = 1'b1;
				zero_ext  = 1'b1;
				dest      = rt;
				reg_write = 1'b1;
			end
			// Address is base plus sign-extended offset, rt only feeds the bus
			`OP_SW: begin
				use_imm   = 1'b1;
				mem_write = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

//--- rtl/mem_writeback.sv
`timescale 1ns/1ps

module mem_writeback (
	input  logic                clk,
	input  logic                rst_n,
	input  mips_pkg::word_t     e_result,
	input  mips_pkg::word_t     e_store_data,
	input  mips_pkg::reg_addr_t e_dest,
	input  logic                e_reg_write,
	input  logic                e_mem_write,
	output mips_pkg::reg_addr_t m_dest,
	output logic                m_reg_write,
	output mips_pkg::word_t     m_result,
	output mips_pkg::reg_addr_t w_dest,
	output logic                w_reg_write,
	output mips_pkg::word_t     w_result,
	output logic                wb_we,
	output mips_pkg::reg_addr_t wb_addr,
	output mips_pkg::word_t     wb_data,
	output mips_pkg::pc_t       CPUAddr,
	output mips_pkg::word_t     CPUOut,
	output logic                IOWe
);
	logic            m_mem_write;
	mips_pkg::word_t m_store_data;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m_reg_write <= 1'b0;
			m_mem_write <= 1'b0;
			w_reg_write <= 1'b0;
		end else begin
			m_reg_write <= e_reg_write;
			m_mem_write <= e_mem_write;
			w_reg_write <= m_reg_write;
		end
	end

	always_ff @(posedge clk) begin
		m_result     <= e_result;
		m_store_data <= e_store_data;
		m_dest       <= e_dest;
		w_result     <= m_result;
		w_dest       <= m_dest;
	end

	// Store bus is driven straight from the M register
	assign CPUAddr = m_result[31:2];
	assign CPUOut  = m_store_data;
	assign IOWe    = m_mem_write;

	assign wb_we   = w_reg_write;
	assign wb_addr = w_dest;
	assign wb_data = w_result;

	// Back-to-back pulses are only legal when a new store came out of E
	a_iowe_once: assert property (
		@(posedge clk) disable iff (!rst_n)
		IOWe |-> $past(e_mem_write)
	) else $error("IOWe held without a new store from E");

endmodule

//--- rtl/mips.sv
`timescale 1ns/1ps

module mips (
	input  logic            clk,
	input  logic            rst_n,
	input  mips_pkg::word_t instr,
	output mips_pkg::pc_t   pc_out,
	output mips_pkg::pc_t   CPUAddr,
	output mips_pkg::word_t CPUOut,
	output logic            IOWe
);
	// D stage fields
	mips_pkg::opcode_t   opcode;
	mips_pkg::funct_t    funct;
	mips_pkg::reg_addr_t rs;
	mips_pkg::reg_addr_t rt;
	mips_pkg::reg_addr_t rd;
	logic [15:0]         imm;

	// Decoded controls
	mips_pkg::alu_op_t   alu_op;
	logic                use_imm;
	logic                zero_ext;
	mips_pkg::reg_addr_t dest;
	logic                reg_write;
	logic                mem_write;
	mips_pkg::word_t     rs_data;
	mips_pkg::word_t     rt_data;

	// E stage
	mips_pkg::reg_addr_t e_rs;
	mips_pkg::reg_addr_t e_rt;
	mips_pkg::word_t     e_result;
	mips_pkg::word_t     e_store_data;
	mips_pkg::reg_addr_t e_dest;
	logic                e_reg_write;
	logic                e_mem_write;
	mips_pkg::fwd_sel_t  fwd_a;
	mips_pkg::fwd_sel_t  fwd_b;

	// M and W stages
	mips_pkg::reg_addr_t m_dest;
	logic                m_reg_write;
	mips_pkg::word_t     m_result;
	mips_pkg::reg_addr_t w_dest;
	logic                w_reg_write;
	mips_pkg::word_t     w_result;
	logic                wb_we;
	mips_pkg::reg_addr_t wb_addr;
	mips_pkg::word_t     wb_data;

	fetch_decode fetch_decode_inst (
		.clk(clk), .rst_n(rst_n), .instr(instr), .pc_out(pc_out),
		.opcode(opcode), .funct(funct), .rs(rs), .rt(rt), .rd(rd), .imm(imm)
	);

	instr_decoder instr_decoder_inst (
		.opcode(opcode), .funct(funct), .rt(rt), .rd(rd),
		.alu_op(alu_op), .use_imm(use_imm), .zero_ext(zero_ext), .dest(dest),
		.reg_write(reg_write), .mem_write(mem_write)
	);

	reg_file reg_file_inst (
		.clk(clk), .rst_n(rst_n), .rs(rs), .rt(rt),
		.wb_we(wb_we), .wb_addr(wb_addr), .wb_data(wb_data),
		.rs_data(rs_data), .rt_data(rt_data)
	);

	forward_unit forward_unit_inst (
		.e_rs(e_rs), .e_rt(e_rt),
		.m_dest(m_dest), .m_reg_write(m_reg_write),
		.w_dest(w_dest), .w_reg_write(w_reg_write),
		.fwd_a(fwd_a), .fwd_b(fwd_b)
	);

	execute_stage execute_stage_inst (
		.clk(clk), .rst_n(rst_n),
		.alu_op(alu_op), .use_imm(use_imm), .zero_ext(zero_ext), .dest(dest),
		.reg_write(reg_write), .mem_write(mem_write),
		.rs(rs), .rt(rt), .imm(imm), .rs_data(rs_data), .rt_data(rt_data),
		.fwd_a(fwd_a), .fwd_b(fwd_b), .m_result(m_result), .w_result(w_result),
		.e_rs(e_rs), .e_rt(e_rt), .e_result(e_result), .e_store_data(e_store_data),
		.e_dest(e_dest), .e_reg_write(e_reg_write), .e_mem_write(e_mem_write)
	);

	mem_writeback mem_writeback_inst (
		.clk(clk), .rst_n(rst_n),
		.e_result(e_result), .e_store_data(e_store_data), .e_dest(e_dest),
		.e_reg_write(e_reg_write), .e_mem_write(e_mem_write),
		.m_dest(m_dest), .m_reg_write(m_reg_write), .m_result(m_result),
		.w_dest(w_dest), .w_reg_write(w_reg_write), .w_result(w_result),
		.wb_we(wb_we), .wb_addr(wb_addr), .wb_data(wb_data),
		.CPUAddr(CPUAddr), .CPUOut(CPUOut), .IOWe(IOWe)
	);

endmodule

//--- rtl/mips_pkg.sv
package mips_pkg;

	// Data word and word address (byte address bits 31 to 2)
	typedef logic [31:0] word_t;
	typedef logic [31:2] pc_t;

	// Instruction fields
	typedef logic [4:0] reg_addr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	// ALU operations
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_lui
	} alu_op_t;

	// Source of an execute operand
	typedef enum logic [1:0] {
		fwd_from_reg,
		fwd_from_m,
		fwd_from_w
	} fwd_sel_t;

endpackage

//--- rtl/mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Primary opcodes
`define OP_SPECIAL 6'h00
`define OP_ADDIU   6'h09
`define OP_ORI     6'h0d
`define OP_LUI     6'h0f
`define OP_SW      6'h2b

// Function codes of the SPECIAL opcode
`define FN_ADDU    6'h21
`define FN_SUBU    6'h23
`define FN_AND     6'h24
`define FN_OR      6'h25
`define FN_SLT     6'h2a

// Word address of the first fetch
`define RESET_PC   30'd0

`define REG_ZERO   5'd0

`endif

//--- rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                clk,
	input  logic                rst_n,
	input  mips_pkg::reg_addr_t rs,
	input  mips_pkg::reg_addr_t rt,
	input  logic                wb_we,
	input  mips_pkg::reg_addr_t wb_addr,
	input  mips_pkg::word_t     wb_data,
	output mips_pkg::word_t     rs_data,
	output mips_pkg::word_t     rt_data
);
	mips_pkg::word_t regs [32];

	// Register zero is cleared by reset and never written afterwards
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			regs[0] <= '0;
		end else if (wb_we && wb_addr != 5'd0) begin
			regs[wb_addr] <= wb_data;
		end
	end

	// A read of the register being written returns the new data
	function automatic mips_pkg::word_t read_port(input mips_pkg::reg_addr_t addr);
		if (wb_we && addr != 5'd0 && wb_addr == addr) begin
			return wb_data;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rs_data = read_port(rs);
		rt_data = read_port(rt);
	end

	a_zero_reads_zero: assert property (
		@(posedge clk) disable iff (!rst_n)
		(rs != 5'd0 || rs_data == '0) && (rt != 5'd0 || rt_data == '0)
	) else $error("register zero read back nonzero");

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module mips_tb -f mips_core.f -o mips_sim \
	&& ./obj_dir/mips_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Simulation passed" sim.log 2>/dev/null && echo "run_sim: PASS" \
	|| { echo "run_sim: FAIL"; exit 1; }
exit 0

//--- tests/mips_stimulus.txt
# T <name> starts a test, I <hex word> is the next program word from address 0
# E <hex word address> <hex data> is an expected store, in bus order
T alu_reg
I 24011234
I 2402fff0
I 00221821
I 00222023
I 00222824
I 00223025
I 0041382a
I ac030010
I ac040014
I ac050018
I ac06001c
I ac070020
E 00000004 00001224
E 00000005 00001244
E 00000006 00001230
E 00000007 fffffff4
E 00000008 00000001
T alu_imm
I 24098001
I 340a8001
I 3c0babcd
I ac090030
I ac0a0034
I ac0b0038
E 0000000c ffff8001
E 0000000d 00008001
E 0000000e abcd0000
T forwarding
I 240c0005
I 258d0007
I 258e0009
I 258f0001
I ac0f0040
I ac0e0044
I ac0d0048
E 00000010 00000006
E 00000011 0000000e
E 00000012 0000000c
T reg_zero
I 24000055
I 34000077
I ac000050
I 00008021
I ac100054
E 00000014 00000000
E 00000015 00000000
T store_bus
I 24110200
I 24125a5a
I ae320008
I ae31fffc
I ae320000
E 00000082 00005a5a
E 0000007f 00000200
E 00000080 00005a5a

//--- tests/mips_tb.sv
`timescale 1ns/1ps

module mips_tb;
	localparam int PROG_WORDS     = 256;
	localparam int MAX_TESTS      = 16;
	localparam int MAX_ITEMS      = 128;
	localparam int TIMEOUT_CYCLES = 200;

	logic            clk;
	logic            rst_n;
	mips_pkg::word_t instr;
	mips_pkg::pc_t   pc_out;
	mips_pkg::pc_t   CPUAddr;
	mips_pkg::word_t CPUOut;
	logic            IOWe;

	mips_pkg::word_t program_mem [PROG_WORDS];

	// Tests as read from the stimulus file
	string           test_name [MAX_TESTS];
	int              prog_first [MAX_TESTS];
	int              prog_count [MAX_TESTS];
	int              exp_first [MAX_TESTS];
	int              exp_count [MAX_TESTS];
	mips_pkg::word_t prog_words [MAX_ITEMS];
	mips_pkg::pc_t   exp_addr [MAX_ITEMS];
	mips_pkg::word_t exp_data [MAX_ITEMS];
	int              num_tests;
	int              num_words;
	int              num_exp;
	bit              load_ok;

	// Stores seen on the bus, oldest first
	mips_pkg::pc_t   seen_addr [$];
	mips_pkg::word_t seen_data [$];

	mips mips_inst (
		.clk(clk), .rst_n(rst_n), .instr(instr), .pc_out(pc_out),
		.CPUAddr(CPUAddr), .CPUOut(CPUOut), .IOWe(IOWe)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Instruction memory answers pc_out, updated on the falling edge
	initial begin
		instr = '0;
		forever begin
			@(negedge clk);
			instr = program_mem[pc_out[9:2]];
		end
	end

	always @(negedge clk) begin
		if (rst_n && IOWe) begin
			seen_addr.push_back(CPUAddr);
			seen_data.push_back(CPUOut);
		end
	end

	// sll with rd zero, random rt and shamt mixed with the address
	function automatic mips_pkg::word_t noop_word(input int addr);
		logic [31:0] r;
		r = $urandom;
		r = r ^ addr;
		return {6'h00, 5'h00, r[4:0], 5'h00, r[9:5], 6'h00};
	endfunction

	task automatic load_stimulus();
		int              fd;
		int              code;
		string           tag;
		string           name;
		logic [31:0]     a;
		logic [31:0]     d;
		logic [8*160-1:0] rest;
		num_tests = 0;
		num_words = 0;
		num_exp   = 0;
		load_ok   = 1'b1;
		fd = $fopen("tests/mips_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open tests/mips_stimulus.txt");
			load_ok = 1'b0;
			return;
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, " %s", tag);
			if (code != 1) break;
			if (tag == "T" && num_tests < MAX_TESTS) begin
				code = $fscanf(fd, " %s", name);
				test_name[num_tests]  = name;
				prog_first[num_tests] = num_words;
				prog_count[num_tests] = 0;
				exp_first[num_tests]  = num_exp;
				exp_count[num_tests]  = 0;
				num_tests++;
			end else if (tag == "I" && num_tests > 0 && num_words < MAX_ITEMS) begin
				code = $fscanf(fd, " %h", d);
				prog_words[num_words] = d;
				num_words++;
				prog_count[num_tests-1]++;
			end else if (tag == "E" && num_tests > 0 && num_exp < MAX_ITEMS) begin
				code = $fscanf(fd, " %h %h", a, d);
				exp_addr[num_exp] = a[29:0];
				exp_data[num_exp] = d;
				num_exp++;
				exp_count[num_tests-1]++;
			end else begin
				// Comment or unknown tag, skip the rest of the line
				code = $fgets(rest, fd);
			end
		end
		$fclose(fd);
	endtask

	task automatic load_program(input int t);
		int a;
		for (a = 0; a < PROG_WORDS; a++) begin
			program_mem[a] = noop_word(a);
		end
		for (a = 0; a < prog_count[t]; a++) begin
			program_mem[a] = prog_words[prog_first[t] + a];
		end
	endtask

	task automatic run_test(input int t, output int test_errors);
		int              cycles;
		int              k;
		int              idx;
		int              limit;
		bit              timed_out;
		logic [31:0]     pc_word;
		mips_pkg::pc_t   got_addr;
		mips_pkg::word_t got_data;
		test_errors = 0;
		timed_out   = 1'b0;
		load_program(t);

		@(negedge clk);
		rst_n = 1'b0;
		for (k = 0; k < 16; k++) begin
			@(negedge clk);
			if (IOWe !== 1'b0) begin
				$display("Error: test %s reset IOWe expected 0 actual %b", test_name[t], IOWe);
				test_errors++;
			end
			if (pc_out !== 30'd0) begin
				$display("Error: test %s reset pc_out expected %h actual %h",
					test_name[t], 30'd0, pc_out);
				test_errors++;
			end
		end
		seen_addr.delete();
		seen_data.delete();
		rst_n = 1'b1;

		for (k = 0; k < exp_count[t] && !timed_out; k++) begin
			idx = exp_first[t] + k;
			cycles = 0;
			while (seen_addr.size() == 0 && cycles < TIMEOUT_CYCLES) begin
				@(posedge clk);
				cycles++;
			end
			if (seen_addr.size() == 0) begin
				$display("Test %s timed out waiting for store %0d on the bus", test_name[t], k);
				test_errors++;
				timed_out = 1'b1;
			end else begin
				got_addr = seen_addr.pop_front();
				got_data = seen_data.pop_front();
				if (got_addr !== exp_addr[idx]) begin
					$display("Error: test %s store %0d CPUAddr expected %h actual %h",
						test_name[t], k, exp_addr[idx], got_addr);
					test_errors++;
				end
				if (got_data !== exp_data[idx]) begin
					$display("Error: test %s store %0d CPUOut expected %h actual %h",
						test_name[t], k, exp_data[idx], got_data);
					test_errors++;
				end
			end
		end

		// Let the tail of the program drain through the pipeline
		limit = prog_count[t] + 8;
		cycles = 0;
		pc_word = {2'b00, pc_out};
		while (pc_word < limit && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
			pc_word = {2'b00, pc_out};
		end
		@(posedge clk);
		if (pc_word < limit) begin
			$display("Test %s timed out because pc_out stopped advancing", test_name[t]);
			test_errors++;
		end
		if (seen_addr.size() != 0) begin
			$display("Test %s saw %0d stores that the program does not make",
				test_name[t], seen_addr.size());
			test_errors++;
		end
	endtask

	initial begin
		int t;
		int test_errors;
		int errors;
		int tests_passed;
		int tests_failed;
		rst_n        = 1'b0;
		errors       = 0;
		tests_passed = 0;
		tests_failed = 0;
		void'($urandom(32'h05ee78b3));
		load_stimulus();
		if (!load_ok || num_tests == 0) begin
			$display("No tests could be read from the stimulus file");
			errors++;
		end else begin
			for (t = 0; t < num_tests; t++) begin
				run_test(t, test_errors);
				if (test_errors == 0) begin
					$display("Test %s passed", test_name[t]);
					tests_passed++;
				end else begin
					$display("Test %s failed with %0d errors", test_name[t], test_errors);
					tests_failed++;
					errors += test_errors;
				end
			end
		end
		$display("%0d tests run, %0d passed, %0d failed, %0d errors",
			num_tests, tests_passed, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
